// File: rom.hex
// boot ROM image, one 64-bit word per line, word 0 first
0123456789AB0000
0123456789AB1111
0123456789AB2222
0123456789AB3333
0123456789AB4444
0123456789AB5555
0123456789AB6666
0123456789AB7777
0123456789AB8888
0123456789AB9999
0123456789ABAAAA
0123456789ABBBBB
0123456789ABCCCC
0123456789ABDDDD
0123456789ABEEEE
0123456789ABFFFF

// File: ringL2Top.f
hdl/ringPkg.sv
hdl/accessTimer.sv
hdl/ringMemNode.sv
hdl/ringRomNode.sv
hdl/mmioSequencer.sv
hdl/ringMmioNode.sv
hdl/ringL2Top.sv
verif/ringL2Tb.sv

// File: run.sh
#!/bin/sh
# build the ring segment testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	-f ringL2Top.f --top-module ringL2Tb -o ringL2Sim
./obj_dir/ringL2Sim > sim.log
cat sim.log
if grep -qx "TEST PASS" sim.log
then
	exit 0
fi
exit 1

// File: verif/ringL2Tb.sv
// ring segment testbench with reference model, MMIO device model and tag scoreboard
`timescale 1ns/1ns
module ringL2Tb;
	import ringPkg::*;

	localparam int MemWords = 64;
	localparam int MemLatency = 4;
	localparam int IdxWidth = $clog2(MemWords);
	localparam int StreamLen = 48; // slots in the back-pressure stream
	localparam int TotalReqs = 8 + 8 + 16 + 2 + 8 + StreamLen;
	localparam int CycleLimit = TotalReqs * (MemLatency + 8) + 200;

	logic clock;
	logic arstN;
	logic [SeqWidth-1:0] seqIn;
	ringOp opmIn;
	logic [AddrWidth-1:0] addrIn;
	logic [DataWidth-1:0] dataIn;
	logic [SeqWidth-1:0] seqOut;
	ringOp opmOut;
	logic [AddrWidth-1:0] addrOut;
	logic [DataWidth-1:0] dataOut;
	logic [AddrWidth-1:0] mmioAddr;
	logic [DataWidth-1:0] mmioOutData;
	ringOp mmioOpm;
	logic [DataWidth-1:0] mmioInData;
	mmioStatus mmioOK;

	// outstanding requests, tag is the index
	logic pendValid [256];
	logic pendBounced [256];
	ringOp pendOp [256];
	logic [AddrWidth-1:0] pendAddr [256];
	logic [DataWidth-1:0] pendData [256];
	int pendSent [256]; // cycle of the last send
	logic [SeqWidth-1:0] resendQ [$]; // unserved tags
	logic [DataWidth-1:0] memModel [MemWords];
	logic [DataWidth-1:0] mmioModel [16];
	logic [AddrWidth-1:0] memAddrs [8]; // words written in the memory test
	logic [SeqWidth-1:0] nextTag;
	logic [31:0] lfsr;
	int cycleCount;
	int outstanding;
	int checkCount;
	int errorCount;
	int errBefore;
	int bounceIdx;

	// device side
	logic [DataWidth-1:0] devRegs [16];
	logic devBusy;
	int devWait;
	ringOp devOp;
	logic [AddrWidth-1:0] devAddr;
	logic [DataWidth-1:0] devData;

	ringL2Top #(.MemWords(MemWords), .MemLatency(MemLatency)) uut (.*);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [63:0] takeBits(int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [DataWidth-1:0] romWord(int i);
		return 64'h0123_4567_89AB_0000 + 64'(i) * 64'h1111;
	endfunction

	// register fill, every index gives a different word
	function automatic logic [DataWidth-1:0] fillWord(int i);
		return {16'hfeed, 16'(i), 32'(i) * 32'h0101_0101};
	endfunction

	function automatic logic [AddrWidth-1:0] mmioAddress(logic err, logic [3:0] regIdx);
		return {4'hF, 15'(takeBits(15)), err, 5'd0, regIdx, 3'd0}; // bit 12 makes the device fail
	endfunction

	// expected {opcode, data} of a served slot; stores update the models
	function automatic logic [71:0] refRing(ringOp op, logic [AddrWidth-1:0] addr,
		logic [DataWidth-1:0] data);
		logic [IdxWidth-1:0] w;
		w = addr[3 +: IdxWidth];
		case (addr[31:28])
			RegionRom:
				return (op == opLoad) ? {opLoadOk, romWord(int'(addr[6:3]))} : {opFault, 64'd0};
			RegionMem:
			begin
				if (op == opLoad)
					return {opLoadOk, memModel[w]};
				memModel[w] = data;
				return {opStoreOk, data}; // write echo
			end
			RegionMmio:
			begin
				if (addr[12])
					return {opFault, 64'd0};
				if (op == opLoad)
					return {opLoadOk, mmioModel[addr[6:3]]};
				mmioModel[addr[6:3]] = data;
				return {opStoreOk, data};
			end
			default:
				return {op, data}; // unmapped, untouched
		endcase
	endfunction

	task automatic reportMismatch(string name, logic [SeqWidth-1:0] tag, logic [63:0] got,
		logic [63:0] want);
		$display("Fail %s tag %h: got %h, expected %h", name, tag, got, want);
		errorCount++;
	endtask

	// one slot per edge, idx below zero drives an empty slot
	task automatic sendSlot(int idx);
		@(posedge clock);
		#10;
		if (idx < 0)
		begin
			seqIn = '0;
			opmIn = opNone;
			addrIn = '0;
			dataIn = '0;
		end
		else
		begin
			seqIn = SeqWidth'(idx);
			opmIn = pendOp[idx];
			addrIn = pendAddr[idx];
			dataIn = pendData[idx];
			pendSent[idx] = cycleCount;
		end
	endtask

	task automatic newRequest(ringOp op, logic [AddrWidth-1:0] addr, logic [DataWidth-1:0] data);
		int idx;
		idx = int'(nextTag[7:0]);
		pendValid[idx] = 1'b1;
		pendBounced[idx] = 1'b0;
		pendOp[idx] = op;
		pendAddr[idx] = addr;
		pendData[idx] = data;
		nextTag = nextTag + 16'd1;
		outstanding++;
		sendSlot(idx);
	endtask

	// resend unserved slots until every request is answered
	task automatic drainRing();
		while (outstanding > 0)
		begin
			if (resendQ.size() > 0)
				sendSlot(int'(resendQ.pop_front()));
			sendSlot(-1); // gap so a held response gets back on the ring
		end
	endtask

	task automatic endTest(string name);
		drainRing();
		$display("%s finished with %0d errors", name, errorCount - errBefore);
		errBefore = errorCount;
	endtask

	task automatic checkSlot();
		int idx;
		logic [71:0] want;
		idx = int'(seqOut[7:0]);
		assert (pendValid[idx]) else
		begin
			$display("slot with tag %h came out with no request outstanding", seqOut);
			errorCount++;
		end
		if (pendValid[idx])
		begin
			checkCount++;
			assert (addrOut == pendAddr[idx]) else
				reportMismatch("addrOut", seqOut, 64'(addrOut), 64'(pendAddr[idx]));
			if (opmOut[7:6] == 2'b10 && addrOut[31:28] != 4'h2)
			begin
				// unserved, must be untouched
				assert (opmOut == pendOp[idx]) else
					reportMismatch("opmOut", seqOut, 64'(opmOut), 64'(pendOp[idx]));
				pendBounced[idx] = 1'b1;
				resendQ.push_back(seqOut);
			end
			else
			begin
				want = refRing(pendOp[idx], pendAddr[idx], pendData[idx]);
				assert (opmOut == want[71:64]) else
					reportMismatch("opmOut", seqOut, 64'(opmOut), 64'(want[71:64]));
				assert (dataOut == want[63:0]) else
					reportMismatch("dataOut", seqOut, dataOut, want[63:0]);
				if (pendAddr[idx][31:28] == RegionRom || pendAddr[idx][31:28] == 4'h2)
				begin
					assert (cycleCount - pendSent[idx] == 3) else
					begin
						$display("slot with tag %h took %0d cycles instead of 3", seqOut,
							cycleCount - pendSent[idx]);
						errorCount++;
					end
				end
				if (pendAddr[idx][31:28] == RegionMem)
				begin
					// capture one edge after the send, then two stops behind
					assert (cycleCount - pendSent[idx] >= MemLatency + 3) else
					begin
						$display("memory response with tag %h came after %0d cycles, %s",
							seqOut, cycleCount - pendSent[idx], "before the access latency");
						errorCount++;
					end
				end
				pendValid[idx] = 1'b0;
				outstanding--;
			end
		end
	endtask

	// outputs settle after the rising edge, compare at the falling one
	always @(negedge clock)
	begin
		if (arstN && opmOut != opNone)
			checkSlot();
	end

	// MMIO device with an answer delay of 1 to 4 cycles
	always @(posedge clock)
	begin : devModel
		logic found;
		#10;
		if (devBusy && mmioOK != stWait)
		begin
			mmioOK = stWait; // answer taken at this edge
			devBusy = 1'b0;
		end
		else if (devBusy)
		begin
			assert (mmioOpm == devOp && mmioAddr == devAddr && mmioOutData == devData) else
			begin
				$display("MMIO port changed before the device answered");
				errorCount++;
			end
			if (devWait > 1)
				devWait--;
			else if (devAddr[12])
				mmioOK = stErr;
			else
			begin
				mmioOK = stDone;
				if (devOp == opStore)
					devRegs[devAddr[6:3]] = devData;
				else
					mmioInData = devRegs[devAddr[6:3]];
			end
		end
		else if (mmioOpm != opNone)
		begin
			found = 1'b0;
			for (int i = 0; i < 256; i++)
				if (pendValid[i] && pendAddr[i] == mmioAddr && pendOp[i] == mmioOpm
					&& pendData[i] == mmioOutData)
					found = 1'b1;
			assert (found) else
			begin
				$display("MMIO port shows an access that no outstanding request asked for");
				errorCount++;
			end
			devBusy = 1'b1;
			devWait = 1 + int'(takeBits(2));
			devOp = mmioOpm;
			devAddr = mmioAddr;
			devData = mmioOutData;
		end
	end

	// run limit
	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount > CycleLimit)
		begin
			$display("timeout after %0d cycles, %0d requests never answered", cycleCount,
				outstanding);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		lfsr = 32'h1e82;
		arstN = 1'b0;
		seqIn = '0;
		opmIn = opNone;
		addrIn = '0;
		dataIn = '0;
		mmioInData = '0;
		mmioOK = stWait;
		devBusy = 1'b0;
		devWait = 0;
		nextTag = '0;
		cycleCount = 0;
		outstanding = 0;
		checkCount = 0;
		errorCount = 0;
		errBefore = 0;
		for (int i = 0; i < 256; i++)
			pendValid[i] = 1'b0;
		for (int i = 0; i < 16; i++)
		begin
			mmioModel[i] = fillWord(i);
			devRegs[i] = fillWord(i);
		end
		repeat (2) @(posedge clock);
		#10 arstN = 1'b1;

		for (int i = 0; i < 8; i++) // region 2 passes through
			newRequest((takeBits(1) == 64'd1) ? opStore : opLoad, {4'h2, 28'(takeBits(28))},
				takeBits(64));
		endTest("unmapped pass-through");

		for (int i = 0; i < 8; i++)
			newRequest((i % 4 == 1) ? opStore : opLoad, {4'h0, 21'(takeBits(21)),
				4'(takeBits(4)), 3'd0}, takeBits(64));
		endTest("boot ROM");

		for (int i = 0; i < 8; i++)
		begin
			memAddrs[i] = {4'h1, 19'(takeBits(19)), 6'(takeBits(6)), 3'd0};
			newRequest(opStore, memAddrs[i], takeBits(64));
		end
		drainRing(); // stores land before any load
		for (int i = 0; i < 8; i++)
			newRequest(opLoad, memAddrs[7 - i], takeBits(64));
		endTest("local memory");

		newRequest(opStore, memAddrs[0], takeBits(64));
		bounceIdx = int'(nextTag[7:0]);
		newRequest(opLoad, memAddrs[1], '0); // holder still busy
		drainRing();
		assert (pendBounced[bounceIdx]) else
		begin
			$display("second back to back memory request was served instead of returned");
			errorCount++;
		end
		endTest("memory back to back");

		for (int i = 0; i < 8; i++)
			newRequest((i % 2 == 0) ? opStore : opLoad, mmioAddress(i % 3 == 2, 4'(i / 2)),
				takeBits(64));
		endTest("MMIO access");

		// dense pass-through traffic with random gaps
		for (int i = 0; i < StreamLen; i++)
		begin
			if (i % 8 == 3)
				newRequest((i % 16 == 3) ? opStore : opLoad, memAddrs[int'(takeBits(3))],
					takeBits(64));
			else if (i % 8 == 7)
				newRequest((i % 16 == 7) ? opStore : opLoad,
					mmioAddress(i % 24 == 7, 4'(takeBits(4))), takeBits(64));
			else if (takeBits(2) == 64'd0)
				sendSlot(-1);
			else
				newRequest(opLoad, {4'h2, 28'(takeBits(28))}, takeBits(64));
		end
		endTest("back-pressure");

		$display("summary: %0d slots checked, %0d errors, %0d outstanding", checkCount,
			errorCount, outstanding);
		if (errorCount == 0 && outstanding == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: hdl/ringL2Top.sv
// ring segment top chaining the local memory, boot ROM and MMIO stops
`timescale 1ns/1ns
module ringL2Top #(
	parameter int MemWords = 64,
	parameter int MemLatency = 4
) (
	input logic clock,
	input logic arstN,
	input logic [ringPkg::SeqWidth-1:0] seqIn,
	input ringPkg::ringOp opmIn,
	input logic [ringPkg::AddrWidth-1:0] addrIn,
	input logic [ringPkg::DataWidth-1:0] dataIn,
	output logic [ringPkg::SeqWidth-1:0] seqOut,
	output ringPkg::ringOp opmOut,
	output logic [ringPkg::AddrWidth-1:0] addrOut,
	output logic [ringPkg::DataWidth-1:0] dataOut,
	output logic [ringPkg::AddrWidth-1:0] mmioAddr,
	output logic [ringPkg::DataWidth-1:0] mmioOutData,
	output ringPkg::ringOp mmioOpm,
	input logic [ringPkg::DataWidth-1:0] mmioInData,
	input ringPkg::mmioStatus mmioOK
);
	import ringPkg::*;

	// memory stop to rom stop
	logic [SeqWidth-1:0] memSeq;
	ringOp memOpm;
	logic [AddrWidth-1:0] memAddr;
	logic [DataWidth-1:0] memData;

	// rom stop to mmio stop
	logic [SeqWidth-1:0] romSeq;
	ringOp romOpm;
	logic [AddrWidth-1:0] romAddr;
	logic [DataWidth-1:0] romData;

	ringMemNode #(.MemWords(MemWords), .MemLatency(MemLatency)) memNode (
		.clock(clock), .arstN(arstN),
		.seqIn(seqIn), .opmIn(opmIn), .addrIn(addrIn), .dataIn(dataIn),
		.seqOut(memSeq), .opmOut(memOpm), .addrOut(memAddr), .dataOut(memData)
	);

	ringRomNode romNode (
		.clock(clock), .arstN(arstN),
		.seqIn(memSeq), .opmIn(memOpm), .addrIn(memAddr), .dataIn(memData),
		.seqOut(romSeq), .opmOut(romOpm), .addrOut(romAddr), .dataOut(romData)
	);

	// last stop drives the segment outputs
	ringMmioNode mmioNode (
		.clock(clock), .arstN(arstN),
		.seqIn(romSeq), .opmIn(romOpm), .addrIn(romAddr), .dataIn(romData),
		.seqOut(seqOut), .opmOut(opmOut), .addrOut(addrOut), .dataOut(dataOut),
		.mmioAddr(mmioAddr),
		.mmioOutData(mmioOutData),
		.mmioOpm(mmioOpm),
		.mmioInData(mmioInData),
		.mmioOK(mmioOK)
	);

endmodule

// File: hdl/ringMmioNode.sv
// MMIO ring stop that turns a request into a held access on the external port
`timescale 1ns/1ns
module ringMmioNode (
	input logic clock,
	input logic arstN,
	input logic [ringPkg::SeqWidth-1:0] seqIn,
	input ringPkg::ringOp opmIn,
	input logic [ringPkg::AddrWidth-1:0] addrIn,
	input logic [ringPkg::DataWidth-1:0] dataIn,
	output logic [ringPkg::SeqWidth-1:0] seqOut,
	output ringPkg::ringOp opmOut,
	output logic [ringPkg::AddrWidth-1:0] addrOut,
	output logic [ringPkg::DataWidth-1:0] dataOut,
	output logic [ringPkg::AddrWidth-1:0] mmioAddr,
	output logic [ringPkg::DataWidth-1:0] mmioOutData,
	output ringPkg::ringOp mmioOpm,
	input logic [ringPkg::DataWidth-1:0] mmioInData,
	input ringPkg::mmioStatus mmioOK
);
	import ringPkg::*;

	logic accept;
	logic capture;
	logic issue;
	logic finish;
	logic failed;
	logic [SeqWidth-1:0] holdSeq; // request held during the access
	ringOp holdOpm;
	logic [AddrWidth-1:0] holdAddr;
	logic [DataWidth-1:0] holdData;
	logic [DataWidth-1:0] rdData; // device read word
	ringOp rspOpm;
	logic [DataWidth-1:0] rspData;

	assign accept = isRequest(opmIn) && (regionOf(addrIn) == RegionMmio);

	mmioSequencer sequencer (
		.clock(clock),
		.arstN(arstN),
		.accept(accept),
		.status(mmioOK),
		.slotFree(opmIn == opNone), // reinsert only into an empty slot
		.capture(capture),
		.issue(issue),
		.finish(finish),
		.failed(failed)
	);

	assign mmioOpm = issue ? holdOpm : opNone;
	assign mmioAddr = holdAddr; // steady for the whole access
	assign mmioOutData = holdData;

	always_ff @(posedge clock)
	begin
		if (capture)
		begin
			holdSeq <= seqIn;
			holdOpm <= opmIn;
			holdAddr <= addrIn;
			holdData <= dataIn;
		end
		if (issue && (mmioOK == stDone))
			rdData <= mmioInData;
	end

	always_comb
	begin
		rspOpm = (holdOpm == opLoad) ? opLoadOk : opStoreOk;
		rspData = (holdOpm == opLoad) ? rdData : holdData; // store echoes
		if (failed)
		begin
			rspOpm = opFault;
			rspData = '0;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			opmOut <= opNone;
		else if (capture)
			opmOut <= opNone; // request leaves the ring
		else if (finish)
			opmOut <= rspOpm;
		else
			opmOut <= opmIn;
	end

	always_ff @(posedge clock)
	begin
		seqOut <= finish ? holdSeq : seqIn; // tag and address kept from request
		addrOut <= finish ? holdAddr : addrIn;
		dataOut <= finish ? rspData : dataIn;
	end

endmodule

// File: hdl/mmioSequencer.sv
// FSM that runs one MMIO access from issue until the device reports status
`timescale 1ns/1ns
module mmioSequencer (
	input logic clock,
	input logic arstN,
	input logic accept,
	input ringPkg::mmioStatus status,
	input logic slotFree,
	output logic capture,
	output logic issue,
	output logic finish,
	output logic failed
);
	import ringPkg::*;

	typedef enum logic [1:0] {seqIdle, seqAccess, seqReply} seqState;

	seqState state;
	seqState nxtState;

	assign capture = (state == seqIdle) && accept; // claim only when idle
	assign issue = (state == seqAccess); // port held while waiting
	assign finish = (state == seqReply) && slotFree;

	always_comb
	begin
		nxtState = state;
		case (state)
			seqIdle:
			begin
				if (accept)
					nxtState = seqAccess;
			end
			seqAccess:
			begin
				if (status != stWait)
					nxtState = seqReply; // device answered
			end
			seqReply:
			begin
				if (slotFree)
					nxtState = seqIdle;
			end
			default:
				nxtState = seqIdle;
		endcase
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= seqIdle;
			failed <= 1'b0;
		end
		else
		begin
			state <= nxtState;
			if (capture)
				failed <= 1'b0; // fresh access
			else if (issue && (status != stWait))
				failed <= (status == stErr);
		end
	end

endmodule

// File: hdl/ringRomNode.sv
// boot ROM ring stop that answers loads in the cycle they arrive
`timescale 1ns/1ns
module ringRomNode (
	input logic clock,
	input logic arstN,
	input logic [ringPkg::SeqWidth-1:0] seqIn,
	input ringPkg::ringOp opmIn,
	input logic [ringPkg::AddrWidth-1:0] addrIn,
	input logic [ringPkg::DataWidth-1:0] dataIn,
	output logic [ringPkg::SeqWidth-1:0] seqOut,
	output ringPkg::ringOp opmOut,
	output logic [ringPkg::AddrWidth-1:0] addrOut,
	output logic [ringPkg::DataWidth-1:0] dataOut
);
	import ringPkg::*;

	localparam int RomWords = 16;
	localparam int RomIdxWidth = $clog2(RomWords);

	logic [DataWidth-1:0] rom [RomWords];
	logic hit; // region matches
	ringOp nxtOpm;
	logic [DataWidth-1:0] nxtData;

	initial
	begin
		$readmemh("rom.hex", rom);
	end

	assign hit = (regionOf(addrIn) == RegionRom);

	always_comb
	begin
		nxtOpm = opmIn;
		nxtData = dataIn;
		if (hit && (opmIn == opLoad))
		begin
			nxtOpm = opLoadOk;
			nxtData = rom[addrIn[3 +: RomIdxWidth]];
		end
		else if (hit && (opmIn == opStore))
		begin
			nxtOpm = opFault; // read only
			nxtData = '0;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			opmOut <= opNone;
		else
			opmOut <= nxtOpm;
	end

	// tag and address always carry over
	always_ff @(posedge clock)
	begin
		seqOut <= seqIn;
		addrOut <= addrIn;
		dataOut <= nxtData;
	end

endmodule

// File: hdl/ringMemNode.sv
// local memory ring stop holding one request while the access latency runs
`timescale 1ns/1ns
module ringMemNode #(
	parameter int MemWords = 64,
	parameter int MemLatency = 4
) (
	input logic clock,
	input logic arstN,
	input logic [ringPkg::SeqWidth-1:0] seqIn,
	input ringPkg::ringOp opmIn,
	input logic [ringPkg::AddrWidth-1:0] addrIn,
	input logic [ringPkg::DataWidth-1:0] dataIn,
	output logic [ringPkg::SeqWidth-1:0] seqOut,
	output ringPkg::ringOp opmOut,
	output logic [ringPkg::AddrWidth-1:0] addrOut,
	output logic [ringPkg::DataWidth-1:0] dataOut
);
	import ringPkg::*;

	localparam int IdxWidth = $clog2(MemWords);

	typedef enum logic [1:0] {holdEmpty, holdWait, holdReady} holdState;

	holdState state;
	logic [DataWidth-1:0] mem [MemWords]; // local data array
	logic [IdxWidth-1:0] idx; // word index above the byte offset
	logic capture; // request taken into the holder
	logic insert; // response put into a free slot
	logic timerBusy;
	logic timerDone;

	// pending request holder
	logic [SeqWidth-1:0] holdSeq;
	ringOp holdOpm; // already the response opcode
	logic [AddrWidth-1:0] holdAddr;
	logic [DataWidth-1:0] holdData;

	// slot going into the output register
	logic [SeqWidth-1:0] nxtSeq;
	ringOp nxtOpm;
	logic [AddrWidth-1:0] nxtAddr;
	logic [DataWidth-1:0] nxtData;

	assign idx = addrIn[3 +: IdxWidth];
	assign capture = (state == holdEmpty) && !timerBusy && isRequest(opmIn)
		&& (regionOf(addrIn) == RegionMem);
	assign insert = (state == holdReady) && (opmIn == opNone); // only into empty slots

	accessTimer #(.Cycles(MemLatency)) timer (
		.clock(clock),
		.arstN(arstN),
		.start(capture),
		.busy(timerBusy),
		.done(timerDone)
	);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			state <= holdEmpty;
		else if (capture)
			state <= holdWait;
		else if ((state == holdWait) && timerDone)
			state <= holdReady; // latency served
		else if (insert)
			state <= holdEmpty;
	end

	// array access happens at capture, the timer only models latency
	always_ff @(posedge clock)
	begin
		if (capture)
		begin
			holdSeq <= seqIn;
			holdAddr <= addrIn;
			if (opmIn == opStore)
			begin
				mem[idx] <= dataIn;
				holdOpm <= opStoreOk;
				holdData <= dataIn; // echo
			end
			else
			begin
				holdOpm <= opLoadOk;
				holdData <= mem[idx];
			end
		end
	end

	always_comb
	begin
		nxtSeq = seqIn; // default is pass through
		nxtOpm = opmIn;
		nxtAddr = addrIn;
		nxtData = dataIn;
		if (capture)
		begin
			nxtSeq = '0; // slot freed
			nxtOpm = opNone;
			nxtAddr = '0;
			nxtData = '0;
		end
		else if (insert)
		begin
			nxtSeq = holdSeq;
			nxtOpm = holdOpm;
			nxtAddr = holdAddr;
			nxtData = holdData;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			opmOut <= opNone;
		else
			opmOut <= nxtOpm;
	end

	always_ff @(posedge clock)
	begin
		seqOut <= nxtSeq;
		addrOut <= nxtAddr;
		dataOut <= nxtData;
	end

endmodule

// File: hdl/accessTimer.sv
// down-counter that flags the end of a fixed access latency
`timescale 1ns/1ns
module accessTimer #(
	parameter int Cycles = 4
) (
	input logic clock,
	input logic arstN,
	input logic start,
	output logic busy,
	output logic done
);
	localparam int CntWidth = $clog2(Cycles + 1);

	logic [CntWidth-1:0] count; // cycles left, zero when idle

	assign busy = (count != '0);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0; // single cycle pulse
			if (start && !busy)
				count <= CntWidth'(Cycles); // a start while busy is dropped
			else if (busy)
			begin
				count <= count - 1'b1;
				done <= (count == CntWidth'(1)); // reaching zero
			end
		end
	end

endmodule

// File: hdl/ringPkg.sv
// ring bus shared definitions: opcodes, mmio status codes, address map and field widths
package ringPkg;

	// slot field widths
	localparam int SeqWidth = 16;
	localparam int AddrWidth = 32;
	localparam int DataWidth = 64;

	// region select lives in the top address nibble
	localparam int RegionWidth = 4;
	localparam logic [RegionWidth-1:0] RegionRom = 4'h0;
	localparam logic [RegionWidth-1:0] RegionMem = 4'h1;
	localparam logic [RegionWidth-1:0] RegionMmio = 4'hF;

	// bits 7:6 are the class: 10 request, 01 response
	typedef enum logic [7:0] {
		opNone = 8'h00, // empty slot
		opLoad = 8'h80,
		opStore = 8'h81,
		opLoadOk = 8'h40, // data holds the read word
		opStoreOk = 8'h41, // data echoes the written word
		opFault = 8'h4F // data is zero
	} ringOp;

	// device answer on the mmio port
	typedef enum logic [1:0] {
		stWait = 2'd0, // still busy
		stDone = 2'd1,
		stErr = 2'd3
	} mmioStatus;

	// region code of an address
	function automatic logic [RegionWidth-1:0] regionOf(logic [AddrWidth-1:0] addr);
		return addr[AddrWidth-1 -: RegionWidth];
	endfunction

	// only load and store are claimable requests
	function automatic logic isRequest(ringOp op);
		return (op == opLoad) || (op == opStore);
	endfunction

endpackage
